/* tb.f */
+incdir+hw
hw/common_pkg.sv
hw/bram.sv
hw/wb_addr_decode.sv
hw/wb_ctrl_regs.sv
hw/pet_mem_bus.sv
test/tb_pet_mem_bus.sv

/* test/tb_pet_mem_bus.sv */
`timescale 1ns/1ps
`include "pet_defs.svh"

module tb_pet_mem_bus;

    localparam int CLK_PERIOD  = 4;
    localparam int N_RANDOM    = 200;               // Mixed RAM traffic
    localparam int N_FLOOD     = 260;               // Unmapped hits, past saturation
    localparam int N_FIXED     = 120;               // Directed strobes of the other tests
    localparam int N_STROBES   = N_RANDOM + N_FLOOD + N_FIXED;
    localparam int WATCHDOG_NS = (N_STROBES * 3 + 200) * CLK_PERIOD;

    logic                 wb_clock;
    logic                 rst;
    common_pkg::wb_addr_t wbp_addr;
    common_pkg::wb_data_t wbp_data_w;
    logic                 wbp_we;
    logic                 wbp_cycle;
    logic                 wbp_strobe;
    common_pkg::wb_data_t wbp_data_r;
    logic                 wbp_ack;
    logic                 wbp_stall;

    // Shadow of the whole memory map
    common_pkg::wb_data_t main_m [`MAIN_RAM_DEPTH];
    common_pkg::wb_data_t video_m [`VIDEO_RAM_DEPTH];
    common_pkg::wp_mask_t wp_m;
    common_pkg::wb_data_t count_m;
    common_pkg::wb_data_t scratch_m;

    // Expected responses, one entry per accepted strobe
    common_pkg::wb_data_t next_exp;                 // Travels along with the strobe
    logic                 next_chk;
    common_pkg::wb_data_t exp_q [$];
    logic                 chk_q [$];
    logic                 ack_due;                  // Head of queue, ack expected now
    common_pkg::wb_data_t exp_due;
    logic                 chk_due;

    int err_count;
    int test_errs;
    int tests_passed;
    int tests_failed;

    pet_mem_bus u_dut (
        .wb_clock_i   (wb_clock),
        .rst_i        (rst),
        .wbp_addr_i   (wbp_addr),
        .wbp_data_i   (wbp_data_w),
        .wbp_we_i     (wbp_we),
        .wbp_cycle_i  (wbp_cycle),
        .wbp_strobe_i (wbp_strobe),
        .wbp_data_o   (wbp_data_r),
        .wbp_ack_o    (wbp_ack),
        .wbp_stall_o  (wbp_stall)
    );

    initial begin
        wb_clock = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clock = ~wb_clock;
    end

    // Hard stop sized from the strobe budget
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // Pop on ack, push on accepted strobe, head valid for the next edge
    always @(posedge wb_clock) begin
        if (rst) begin
            exp_q.delete();
            chk_q.delete();
        end else begin
            if (wbp_ack && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(chk_q.pop_front());
            end
            if (wbp_cycle && wbp_strobe) begin
                exp_q.push_back(next_exp);
                chk_q.push_back(next_chk);
            end
        end
        ack_due = exp_q.size() > 0;
        exp_due = ack_due ? exp_q[0] : '0;
        chk_due = ack_due ? chk_q[0] : 1'b0;
    end

    // Ack exactly one cycle after each strobe, never otherwise
    ack_timing: assert property (
        @(posedge wb_clock) disable iff (rst)
        wbp_ack == ack_due
    ) else begin
        $display("ERR %0t wbp_ack_o exp=%0b act=%0b", $time, $sampled(ack_due), $sampled(wbp_ack));
        err_count++;
    end

    read_data: assert property (
        @(posedge wb_clock) disable iff (rst)
        (ack_due && chk_due) |-> (wbp_data_r == exp_due)
    ) else begin
        $display("ERR %0t wbp_data_o exp=%02h act=%02h", $time, $sampled(exp_due),
                 $sampled(wbp_data_r));
        err_count++;
    end

    no_stall: assert property (
        @(posedge wb_clock) disable iff (rst)
        !wbp_stall
    ) else begin
        $display("ERR %0t wbp_stall_o exp=0 act=%0b", $time, $sampled(wbp_stall));
        err_count++;
    end

    // Region of an address, 3 for a hole in the map
    function automatic int region_of(input common_pkg::wb_addr_t a);
        int ai;
        ai = int'(a);
        if (ai >= `MAIN_RAM_BASE && ai < `MAIN_RAM_BASE + `MAIN_RAM_DEPTH) begin
            return 0;
        end else if (ai >= `VIDEO_RAM_BASE && ai < `VIDEO_RAM_BASE + `VIDEO_RAM_DEPTH) begin
            return 1;
        end else if (ai >= `CTRL_BASE && ai < `CTRL_BASE + 16) begin
            return 2;
        end
        return 3;
    endfunction

    function automatic common_pkg::wb_data_t model_read(input common_pkg::wb_addr_t a);
        common_pkg::wb_data_t v;
        case (region_of(a))
            0: v = main_m[a - `MAIN_RAM_BASE];
            1: v = video_m[a - `VIDEO_RAM_BASE];
            2: begin
                case (a[3:0])
                    common_pkg::REG_WP_MASK:        v = wp_m;
                    common_pkg::REG_UNMAPPED_COUNT: v = count_m;
                    common_pkg::REG_SCRATCH:        v = scratch_m;
                    default:                        v = '0;     // Unused index
                endcase
            end
            default: v = `UNMAPPED_DATA;
        endcase
        return v;
    endfunction

    function automatic void model_update(input common_pkg::wb_addr_t a, input logic we,
                                         input common_pkg::wb_data_t d);
        int bank;
        case (region_of(a))
            0: begin
                bank = int'(a - `MAIN_RAM_BASE) >> `WP_BANK_BITS;
                if (we && !wp_m[bank]) begin
                    main_m[a - `MAIN_RAM_BASE] = d;             // Protected bank keeps old byte
                end
            end
            1: begin
                if (we) begin
                    video_m[a - `VIDEO_RAM_BASE] = d;
                end
            end
            2: begin
                if (we && a[3:0] == common_pkg::REG_WP_MASK) begin
                    wp_m = d;
                end else if (we && a[3:0] == common_pkg::REG_UNMAPPED_COUNT) begin
                    count_m = '0;                               // Any write clears
                end else if (we && a[3:0] == common_pkg::REG_SCRATCH) begin
                    scratch_m = d;
                end
            end
            default: begin
                if (count_m != 8'hFF) begin
                    count_m++;                                  // Saturates at 255
                end
            end
        endcase
    endfunction

    function automatic common_pkg::wb_addr_t ctrl_addr(input int idx);
        return 16'(`CTRL_BASE + idx);
    endfunction

    function automatic common_pkg::wb_addr_t bank_addr(input int bank);
        return 16'(`MAIN_RAM_BASE + (bank << `WP_BANK_BITS) + 'h123);
    endfunction

    // Wide spread plus a few hot spots so reads find written data
    function automatic common_pkg::wb_addr_t random_ram_addr();
        int pick;
        pick = $urandom_range(0, 3);
        case (pick)
            0: return 16'(`MAIN_RAM_BASE + $urandom_range(0, `MAIN_RAM_DEPTH - 1));
            1: return 16'(($urandom_range(0, 7) << `WP_BANK_BITS) + $urandom_range(0, 15));
            2: return 16'(`VIDEO_RAM_BASE + $urandom_range(0, `VIDEO_RAM_DEPTH - 1));
            default: return 16'(`VIDEO_RAM_BASE + $urandom_range(0, 15));
        endcase
    endfunction

    function automatic common_pkg::wb_addr_t random_hole();
        case ($urandom_range(0, 2))
            0: return 16'h4000 + 16'($urandom_range(0, 'h3FFF));       // Above main RAM
            1: return 16'h8800 + 16'($urandom_range(0, 'h5FFF));       // Up to control block
            default: return 16'hE810 + 16'($urandom_range(0, 'h17EF)); // Top of the map
        endcase
    endfunction

    // One strobe, model updated as it is issued
    task automatic bus_access(input common_pkg::wb_addr_t a, input logic we,
                              input common_pkg::wb_data_t d);
        common_pkg::wb_data_t v;
        v = model_read(a);
        @(posedge wb_clock);
        wbp_addr   <= a;
        wbp_data_w <= d;
        wbp_we     <= we;
        wbp_cycle  <= 1'b1;
        wbp_strobe <= 1'b1;
        next_exp   <= v;
        next_chk   <= !we;                  // Only reads are compared
        model_update(a, we, d);
    endtask

    // Bus cycle with cycle or strobe low, must be ignored
    task automatic idle_access(input common_pkg::wb_addr_t a, input logic we,
                               input common_pkg::wb_data_t d, input logic cyc, input logic stb);
        @(posedge wb_clock);
        wbp_addr   <= a;
        wbp_data_w <= d;
        wbp_we     <= we;
        wbp_cycle  <= cyc;
        wbp_strobe <= stb;
    endtask

    task automatic drain_bus();
        int waited;
        @(posedge wb_clock);
        wbp_cycle  <= 1'b0;
        wbp_strobe <= 1'b0;
        waited = 0;
        @(negedge wb_clock);
        while ((ack_due || wbp_ack) && waited < 8) begin
            @(negedge wb_clock);
            waited++;
        end
        if (ack_due || wbp_ack) begin
            $display("Bus still busy 8 cycles after the last strobe at %0t", $time);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        drain_bus();
        if (err_count == test_errs) begin
            tests_passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: fail, %0d errors", $time, name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    task automatic test_reset_state();
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);
        bus_access(16'h0000, 1'b0, '0);
        bus_access(16'h3FFF, 1'b0, '0);     // Last main RAM byte
        bus_access(16'h8000, 1'b0, '0);
        bus_access(16'h87FF, 1'b0, '0);
        end_test("reset state");
    endtask

    task automatic test_random_ram();
        common_pkg::wb_addr_t a;
        a = `VIDEO_RAM_BASE;
        for (int i = 0; i < N_RANDOM; i++) begin
            if ($urandom_range(0, 4) != 0) begin
                a = random_ram_addr();      // Otherwise same address again
            end
            bus_access(a, 1'($urandom_range(0, 1)), 8'($urandom));
        end
        end_test("random RAM traffic");
    endtask

    task automatic test_write_protect();
        for (int b = 0; b < 8; b++) begin
            bus_access(bank_addr(b), 1'b1, 8'(8'h10 + b));
        end
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b1, 8'hA5);
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b0, '0);
        for (int b = 0; b < 8; b++) begin
            bus_access(bank_addr(b), 1'b1, 8'(8'hE0 + b));  // Banks 0 2 5 7 hold
        end
        for (int b = 0; b < 8; b++) begin
            bus_access(bank_addr(b), 1'b0, '0);
        end
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b1, 8'h00);
        for (int b = 0; b < 8; b++) begin
            bus_access(bank_addr(b), 1'b1, 8'(8'h30 + b));
            bus_access(bank_addr(b), 1'b0, '0);
        end
        end_test("write protect");
    endtask

    task automatic test_unmapped();
        common_pkg::wb_addr_t holes [6];
        holes = '{16'h4000, 16'h7FFF, 16'h8800, 16'hE7FF, 16'hE810, 16'hFFFF};
        foreach (holes[i]) begin
            bus_access(holes[i], 1'b0, '0);
        end
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);
        for (int i = 0; i < N_FLOOD; i++) begin
            bus_access(random_hole(), 1'($urandom_range(0, 1)), 8'($urandom));
        end
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);    // Stuck at 255
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b1, 8'h5C);
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);
        end_test("unmapped accesses");
    endtask

    task automatic test_ctrl_regs();
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b1, 8'h5A);
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b1, 8'hC3);
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b0, '0);
        for (int idx = 3; idx < 16; idx++) begin
            bus_access(ctrl_addr(idx), 1'b1, 8'(idx * 17));
            bus_access(ctrl_addr(idx), 1'b0, '0);
        end
        // Live registers untouched by the unused indices
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);
        end_test("control registers");
    endtask

    task automatic test_idle_strobes();
        idle_access(16'h0040, 1'b1, 8'h77, 1'b1, 1'b0);     // Cycle without strobe
        idle_access(16'h8040, 1'b1, 8'h88, 1'b0, 1'b1);     // Strobe without cycle
        idle_access(16'h5000, 1'b0, 8'h00, 1'b0, 1'b1);     // Would count as unmapped
        idle_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b1, 8'h11, 1'b1, 1'b0);
        idle_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b1, 8'hFF, 1'b0, 1'b1);
        bus_access(16'h0040, 1'b0, '0);
        bus_access(16'h8040, 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_UNMAPPED_COUNT), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_SCRATCH), 1'b0, '0);
        bus_access(ctrl_addr(common_pkg::REG_WP_MASK), 1'b0, '0);
        end_test("idle strobes");
    endtask

    initial begin
        void'($urandom(61));
        rst          = 1'b1;
        wbp_addr     = '0;
        wbp_data_w   = '0;
        wbp_we       = 1'b0;
        wbp_cycle    = 1'b0;
        wbp_strobe   = 1'b0;
        next_exp     = '0;
        next_chk     = 1'b0;
        err_count    = 0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        wp_m         = '0;
        count_m      = '0;
        foreach (main_m[i]) begin
            main_m[i] = '0;                 // RAMs start cleared
        end
        foreach (video_m[i]) begin
            video_m[i] = '0;
        end
        repeat (2) @(posedge wb_clock);
        rst <= 1'b0;

        test_reset_state();
        test_random_ram();
        test_write_protect();
        test_unmapped();
        test_ctrl_regs();
        test_idle_strobes();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hw/pet_mem_bus.sv */
`timescale 1ns/1ps
`include "pet_defs.svh"

module pet_mem_bus (
    input  logic                 wb_clock_i,
    input  logic                 rst_i,

    // External Wishbone B4 pipelined master port
    input  common_pkg::wb_addr_t wbp_addr_i,
    input  common_pkg::wb_data_t wbp_data_i,
    input  logic                 wbp_we_i,
    input  logic                 wbp_cycle_i,
    input  logic                 wbp_strobe_i,
    output common_pkg::wb_data_t wbp_data_o,
    output logic                 wbp_ack_o,
    output logic                 wbp_stall_o
);
    // Selects from the decoder
    logic                 main_sel;
    logic                 video_sel;
    logic                 ctrl_sel;
    logic                 main_wr_inhibit;
    logic                 unmapped_hit;
    common_pkg::wp_mask_t wp_mask;

    // Peripheral responses
    common_pkg::wb_data_t main_data;
    logic                 main_ack;
    logic                 main_stall;
    common_pkg::wb_data_t video_data;
    logic                 video_ack;
    logic                 video_stall;
    common_pkg::wb_data_t ctrl_data;
    logic                 ctrl_ack;
    logic                 ctrl_stall;

    assign wbp_stall_o = main_stall | video_stall | ctrl_stall;    // All tie low today

    wb_addr_decode u_decode (
        .wb_clock_i        (wb_clock_i),
        .rst_i             (rst_i),
        .wbp_addr_i        (wbp_addr_i),
        .wbp_cycle_i       (wbp_cycle_i),
        .wbp_strobe_i      (wbp_strobe_i),
        .wbp_we_i          (wbp_we_i),
        .wp_mask_i         (wp_mask),
        .main_data_i       (main_data),
        .main_ack_i        (main_ack),
        .video_data_i      (video_data),
        .video_ack_i       (video_ack),
        .ctrl_data_i       (ctrl_data),
        .ctrl_ack_i        (ctrl_ack),
        .main_sel_o        (main_sel),
        .video_sel_o       (video_sel),
        .ctrl_sel_o        (ctrl_sel),
        .main_wr_inhibit_o (main_wr_inhibit),
        .unmapped_hit_o    (unmapped_hit),
        .wbp_data_o        (wbp_data_o),
        .wbp_ack_o         (wbp_ack_o)
    );

    // 16 KiB main RAM, writes gated by the bank mask
    bram #(
        .DATA_DEPTH (`MAIN_RAM_DEPTH)
    ) u_main_ram (
        .wb_clock_i       (wb_clock_i),
        .rst_i            (rst_i),
        .wbp_addr_i       (wbp_addr_i),
        .wbp_data_i       (wbp_data_i),
        .wbp_data_o       (main_data),
        .wbp_we_i         (wbp_we_i),
        .wbp_cycle_i      (wbp_cycle_i),
        .wbp_strobe_i     (wbp_strobe_i),
        .wbp_stall_o      (main_stall),
        .wbp_ack_o        (main_ack),
        .wbp_sel_i        (main_sel),
        .wbp_wr_inhibit_i (main_wr_inhibit)
    );

    // 2 KiB video RAM, never protected
    bram #(
        .DATA_DEPTH (`VIDEO_RAM_DEPTH)
    ) u_video_ram (
        .wb_clock_i       (wb_clock_i),
        .rst_i            (rst_i),
        .wbp_addr_i       (wbp_addr_i),
        .wbp_data_i       (wbp_data_i),
        .wbp_data_o       (video_data),
        .wbp_we_i         (wbp_we_i),
        .wbp_cycle_i      (wbp_cycle_i),
        .wbp_strobe_i     (wbp_strobe_i),
        .wbp_stall_o      (video_stall),
        .wbp_ack_o        (video_ack),
        .wbp_sel_i        (video_sel),
        .wbp_wr_inhibit_i (1'b0)
    );

    wb_ctrl_regs u_ctrl_regs (
        .wb_clock_i     (wb_clock_i),
        .rst_i          (rst_i),
        .wbp_addr_i     (wbp_addr_i),
        .wbp_data_i     (wbp_data_i),
        .wbp_we_i       (wbp_we_i),
        .wbp_cycle_i    (wbp_cycle_i),
        .wbp_strobe_i   (wbp_strobe_i),
        .wbp_sel_i      (ctrl_sel),
        .wbp_data_o     (ctrl_data),
        .wbp_ack_o      (ctrl_ack),
        .wbp_stall_o    (ctrl_stall),
        .unmapped_hit_i (unmapped_hit),
        .wp_mask_o      (wp_mask)
    );

endmodule

/* hw/wb_ctrl_regs.sv */
`timescale 1ns/1ps
`include "pet_defs.svh"

module wb_ctrl_regs (
    input  logic                 wb_clock_i,
    input  logic                 rst_i,

    // Wishbone B4 pipelined peripheral
    input  common_pkg::wb_addr_t wbp_addr_i,
    input  common_pkg::wb_data_t wbp_data_i,
    input  logic                 wbp_we_i,
    input  logic                 wbp_cycle_i,
    input  logic                 wbp_strobe_i,
    input  logic                 wbp_sel_i,         // From the address decoder
    output common_pkg::wb_data_t wbp_data_o,
    output logic                 wbp_ack_o,
    output logic                 wbp_stall_o,

    input  logic                 unmapped_hit_i,    // One pulse per unmapped access
    output common_pkg::wp_mask_t wp_mask_o
);
    common_pkg::ctrl_reg_e reg_idx;
    common_pkg::wp_mask_t  wp_mask_q;
    common_pkg::wb_data_t  count_q;
    common_pkg::wb_data_t  scratch_q;
    common_pkg::wb_data_t  rd_data;
    logic                  access;
    logic                  count_clr;

    assign access      = wbp_sel_i & wbp_cycle_i & wbp_strobe_i;
    assign reg_idx     = common_pkg::ctrl_reg_e'(wbp_addr_i[`CTRL_ADDR_BITS-1:0]);
    assign count_clr   = access & wbp_we_i & (reg_idx == common_pkg::REG_UNMAPPED_COUNT);
    assign wbp_stall_o = 1'b0;
    assign wp_mask_o   = wp_mask_q;

    // Read mux, unused indices read as zero
    always_comb begin
        case (reg_idx)
            common_pkg::REG_WP_MASK:        rd_data = common_pkg::wb_data_t'(wp_mask_q);
            common_pkg::REG_UNMAPPED_COUNT: rd_data = count_q;
            common_pkg::REG_SCRATCH:        rd_data = scratch_q;
            default:                        rd_data = '0;
        endcase
    end

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            wbp_ack_o <= 1'b0;
            wp_mask_q <= '0;                    // Everything writable after reset
            count_q   <= '0;
        end else begin
            wbp_ack_o <= access;
            if (access && wbp_we_i && reg_idx == common_pkg::REG_WP_MASK) begin
                wp_mask_q <= common_pkg::wp_mask_t'(wbp_data_i);
            end
            if (count_clr) begin
                count_q <= '0;                  // Clear wins over a same-cycle hit
            end else if (unmapped_hit_i && count_q != '1) begin
                count_q <= count_q + 1'b1;      // Sticks at 255
            end
        end
    end

    // Read data and scratch byte
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            wbp_data_o <= rd_data;              // Value before any write this cycle
            if (wbp_we_i && reg_idx == common_pkg::REG_SCRATCH) begin
                scratch_q <= wbp_data_i;
            end
        end
    end

    // Saturated counter only leaves 255 through a write
    count_saturates: assert property (
        @(posedge wb_clock_i) disable iff (rst_i)
        (count_q == '1 && !count_clr) |=> (count_q == '1)
    );

endmodule

/* hw/wb_addr_decode.sv */
`timescale 1ns/1ps
`include "pet_defs.svh"

module wb_addr_decode (
    input  logic                 wb_clock_i,
    input  logic                 rst_i,

    // Master request side
    input  common_pkg::wb_addr_t wbp_addr_i,
    input  logic                 wbp_cycle_i,
    input  logic                 wbp_strobe_i,
    input  logic                 wbp_we_i,

    // Protection mask from the control block
    input  common_pkg::wp_mask_t wp_mask_i,

    // Peripheral responses
    input  common_pkg::wb_data_t main_data_i,
    input  logic                 main_ack_i,
    input  common_pkg::wb_data_t video_data_i,
    input  logic                 video_ack_i,
    input  common_pkg::wb_data_t ctrl_data_i,
    input  logic                 ctrl_ack_i,

    // Peripheral selects
    output logic                 main_sel_o,
    output logic                 video_sel_o,
    output logic                 ctrl_sel_o,
    output logic                 main_wr_inhibit_o,
    output logic                 unmapped_hit_o,

    // Merged response to the master
    output common_pkg::wb_data_t wbp_data_o,
    output logic                 wbp_ack_o
);
    localparam int MAIN_BITS  = $clog2(`MAIN_RAM_DEPTH);
    localparam int VIDEO_BITS = $clog2(`VIDEO_RAM_DEPTH);

    // Which source answers in the ack cycle
    typedef enum logic [1:0] {
        SRC_MAIN,
        SRC_VIDEO,
        SRC_CTRL,
        SRC_UNMAPPED
    } src_e;

    logic                 access;
    logic                 main_hit;
    logic                 video_hit;
    logic                 ctrl_hit;
    common_pkg::wp_bank_t bank;
    src_e                 src_d;
    src_e                 src_q;
    logic                 unmapped_ack_q;

    assign access = wbp_cycle_i & wbp_strobe_i;

    // Region compare on the bits above each region's offset
    assign main_hit  = (wbp_addr_i >> MAIN_BITS) == (`MAIN_RAM_BASE >> MAIN_BITS);
    assign video_hit = (wbp_addr_i >> VIDEO_BITS) == (`VIDEO_RAM_BASE >> VIDEO_BITS);
    assign ctrl_hit  = (wbp_addr_i >> `CTRL_ADDR_BITS) == (`CTRL_BASE >> `CTRL_ADDR_BITS);

    assign main_sel_o     = access & main_hit;
    assign video_sel_o    = access & video_hit;
    assign ctrl_sel_o     = access & ctrl_hit;
    assign unmapped_hit_o = access & ~(main_hit | video_hit | ctrl_hit);   // Hole in the map

    // Protection applies per 2 KiB bank, only writes are blocked
    assign bank              = wbp_addr_i[MAIN_BITS-1:`WP_BANK_BITS];
    assign main_wr_inhibit_o = wbp_we_i & wp_mask_i[bank];

    always_comb begin
        if (main_hit) begin
            src_d = SRC_MAIN;
        end else if (video_hit) begin
            src_d = SRC_VIDEO;
        end else if (ctrl_hit) begin
            src_d = SRC_CTRL;
        end else begin
            src_d = SRC_UNMAPPED;
        end
    end

    // Remember the source for the ack cycle, answer unmapped accesses here
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            src_q          <= SRC_MAIN;
            unmapped_ack_q <= 1'b0;
        end else begin
            unmapped_ack_q <= unmapped_hit_o;
            if (access) begin
                src_q <= src_d;     // Holds while idle, its ack stays low
            end
        end
    end

    // Response merge in the ack cycle
    always_comb begin
        case (src_q)
            SRC_MAIN: begin
                wbp_data_o = main_data_i;
                wbp_ack_o  = main_ack_i;
            end
            SRC_VIDEO: begin
                wbp_data_o = video_data_i;
                wbp_ack_o  = video_ack_i;
            end
            SRC_CTRL: begin
                wbp_data_o = ctrl_data_i;
                wbp_ack_o  = ctrl_ack_i;
            end
            default: begin
                wbp_data_o = `UNMAPPED_DATA;    // Open bus reads all ones
                wbp_ack_o  = unmapped_ack_q;
            end
        endcase
    end

    // Regions must not overlap in the address map
    sel_onehot: assert property (
        @(posedge wb_clock_i) disable iff (rst_i)
        $onehot0({main_sel_o, video_sel_o, ctrl_sel_o})
    );

    // Whichever source answers, the master sees its ack one cycle later
    ack_after_access: assert property (
        @(posedge wb_clock_i) disable iff (rst_i)
        access |=> wbp_ack_o
    );

endmodule

/* hw/bram.sv */
`timescale 1ns/1ps
`include "pet_defs.svh"

module bram #(
    parameter int DATA_DEPTH = `VIDEO_RAM_DEPTH,
    parameter int ADDR_WIDTH = $clog2(DATA_DEPTH)
) (
    // Wishbone B4 pipelined peripheral
    input  logic                      wb_clock_i,
    input  logic                      rst_i,
    input  logic [`WB_ADDR_WIDTH-1:0] wbp_addr_i,
    input  logic [   `DATA_WIDTH-1:0] wbp_data_i,
    output logic [   `DATA_WIDTH-1:0] wbp_data_o,
    input  logic                      wbp_we_i,
    input  logic                      wbp_cycle_i,
    input  logic                      wbp_strobe_i,
    output logic                      wbp_stall_o,
    output logic                      wbp_ack_o,
    input  logic                      wbp_sel_i,        // From the address decoder
    input  logic                      wbp_wr_inhibit_i  // Write protect for this access
);
    (* syn_ramstyle = "block_ram" *) logic [`DATA_WIDTH-1:0] mem [DATA_DEPTH];

    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  access;

    // Block RAM powers up undefined, start from a known image
    initial begin
        for (int i = 0; i < DATA_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wbp_stall_o = 1'b0;                          // Single cycle, never stalls
    assign mem_addr    = wbp_addr_i[ADDR_WIDTH-1:0];    // Region offset only
    assign access      = wbp_sel_i & wbp_cycle_i & wbp_strobe_i;

    // Ack one cycle after a selected strobe
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            wbp_ack_o <= 1'b0;
        end else begin
            wbp_ack_o <= access;
        end
    end

    // Read before write, so a write returns the old byte
    always @(posedge wb_clock_i) begin
        if (access) begin
            wbp_data_o <= mem[mem_addr];
            if (wbp_we_i && !wbp_wr_inhibit_i) begin
                mem[mem_addr] <= wbp_data_i;        // Dropped when bank is protected
            end
        end
    end

    // Every ack must belong to the strobe one cycle earlier
    ack_follows_strobe: assert property (
        @(posedge wb_clock_i) disable iff (rst_i)
        wbp_ack_o |-> $past(access)
    );

endmodule

/* hw/common_pkg.sv */
`include "pet_defs.svh"

package common_pkg;

    // Full Wishbone address as driven by the master
    typedef logic [`WB_ADDR_WIDTH-1:0] wb_addr_t;

    // One data byte on the bus
    typedef logic [`DATA_WIDTH-1:0] wb_data_t;

    // One bit per 2 KiB bank of main RAM
    typedef logic [(`MAIN_RAM_DEPTH >> `WP_BANK_BITS)-1:0] wp_mask_t;

    // Bank number inside main RAM, used to index wp_mask_t
    typedef logic [$clog2(`MAIN_RAM_DEPTH >> `WP_BANK_BITS)-1:0] wp_bank_t;

    // Control register index, taken from the low address bits
    // Indices above REG_SCRATCH are unused and read as zero
    typedef enum logic [`CTRL_ADDR_BITS-1:0] {
        REG_WP_MASK        = 4'd0,      // Write protect mask
        REG_UNMAPPED_COUNT = 4'd1,      // Saturating unmapped access count
        REG_SCRATCH        = 4'd2       // Free scratch byte
    } ctrl_reg_e;

endpackage

/* hw/pet_defs.svh */
`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// Wishbone bus widths
`define WB_ADDR_WIDTH 16                // 64 KiB CPU address space
`define DATA_WIDTH 8                    // Byte wide data path

// Memory depths in words
`define MAIN_RAM_DEPTH 16384            // 16 KiB main RAM
`define VIDEO_RAM_DEPTH 2048            // 2 KiB video RAM

// Address map, each base aligned to the size of its region
`define MAIN_RAM_BASE 16'h0000
`define VIDEO_RAM_BASE 16'h8000
`define CTRL_BASE 16'hE800

// Control region is 16 addresses long
`define CTRL_ADDR_BITS 4

// Write protect granularity
`define WP_BANK_BITS 11                 // 2 KiB banks, 8 banks over main RAM

// Value returned for reads that hit no region
`define UNMAPPED_DATA 8'hFF

`endif
